/* filelist.f */
hdl/vga_pkg.sv
hdl/video_timer.sv
hdl/video_frame_ctrl.sv
hdl/video_pattern_gen.sv
hdl/video_core_pipeline.sv
hdl/video_core_stages.sv
hdl/video_core_top.sv
tests/video_core_chk.sv
tests/video_core_tb.sv

/* hdl/vga_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video core shared types
// Pixel colour, frame-control marks, pixel position, pattern modes
// and the request word passed from frame controller to generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vga_pkg;

    // Width of one RGB444 pixel, must match rgb_t
    localparam int RGB_SIZE = 12;

    // RGB444 pixel value
    typedef struct packed {
        logic [3:0] r;              // Red channel
        logic [3:0] g;              // Green channel
        logic [3:0] b;              // Blue channel
    } rgb_t;

    // Frame-control marks travelling with each pixel
    typedef struct packed {
        logic sof;                  // First pixel of frame
        logic eol;                  // Last pixel of line
        logic eof;                  // Last pixel of frame
    } vga_fc_t;

    // Pixel coordinate inside the active area
    typedef struct packed {
        logic [7:0] x;              // Column
        logic [7:0] y;              // Row
    } vga_pos_t;

    // Test pattern selection
    typedef enum logic [1:0] {
        PAT_SOLID = 2'd0,           // Single colour
        PAT_BARS  = 2'd1,           // Eight vertical bars
        PAT_CHECK = 2'd2,           // One pixel checkerboard
        PAT_GRAD  = 2'd3            // Position gradient
    } pat_mode_t;

    // Pixel request, controller to generator
    typedef struct packed {
        vga_pos_t pos;              // Requested position
        vga_fc_t  fc;               // Marks for that pixel
    } pix_req_t;

endpackage

`default_nettype wire

/* hdl/video_core_pipeline.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video core pipeline stage
// Single valid/ready register slice for one pixel and its marks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_core_pipeline #(
    parameter int RGB_SIZE = 12            // Pixel width
) (
    input  logic                    clk,
    input  logic                    reset,

    // Upstream
    input  logic                    pipe_in_vld,
    output logic                    pipe_in_rdy,
    input  vga_pkg::vga_fc_t        pipe_in_fc,
    input  logic [RGB_SIZE-1:0]     pipe_in_rgb,

    // Downstream
    output logic                    pipe_out_vld,
    input  logic                    pipe_out_rdy,
    output vga_pkg::vga_fc_t        pipe_out_fc,
    output logic [RGB_SIZE-1:0]     pipe_out_rgb
);

    logic load;

    // Ready looks through to the next stage
    assign pipe_in_rdy = !pipe_out_vld || pipe_out_rdy;
    assign load        = pipe_in_vld && pipe_in_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_out_vld <= 1'b0;
        end else if (load) begin
            pipe_out_vld <= 1'b1;
        end else if (pipe_out_rdy) begin
            pipe_out_vld <= 1'b0;          // Taken, nothing new
        end
    end

    // Data held until the slice is taken
    always_ff @(posedge clk) begin
        if (load) begin
            pipe_out_fc  <= pipe_in_fc;
            pipe_out_rgb <= pipe_in_rgb;
        end
    end

endmodule

`default_nettype wire

/* hdl/video_core_stages.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video core stages
// Chain of STAGE valid/ready pipeline slices, up to STAGE pixels
// in flight with back-pressure passed through every slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_core_stages #(
    parameter int RGB_SIZE = 12,           // Pixel width
    parameter int STAGE    = 2             // Number of slices
) (
    input  logic                    clk,
    input  logic                    reset,

    // Chain input
    input  logic                    stage_in_vld,
    output logic                    stage_in_rdy,
    input  vga_pkg::vga_fc_t        stage_in_fc,
    input  logic [RGB_SIZE-1:0]     stage_in_rgb,

    // Chain output
    input  logic                    stage_out_rdy,
    output logic                    stage_out_vld,
    output vga_pkg::vga_fc_t        stage_out_fc,
    output logic [RGB_SIZE-1:0]     stage_out_rgb
);

    // Per-slice handshake and payload
    logic             [STAGE-1:0]               pipe_in_vld;
    logic             [STAGE-1:0]               pipe_in_rdy;
    vga_pkg::vga_fc_t [STAGE-1:0]               pipe_in_fc;
    logic             [STAGE-1:0][RGB_SIZE-1:0] pipe_in_rgb;
    logic             [STAGE-1:0]               pipe_out_vld;
    logic             [STAGE-1:0]               pipe_out_rdy;
    vga_pkg::vga_fc_t [STAGE-1:0]               pipe_out_fc;
    logic             [STAGE-1:0][RGB_SIZE-1:0] pipe_out_rgb;

    for (genvar i = 0; i < STAGE; i++) begin : pipe_stage
        video_core_pipeline #(
            .RGB_SIZE     (RGB_SIZE)
        ) u_video_core_pipeline (
            .clk          (clk),
            .reset        (reset),
            .pipe_in_vld  (pipe_in_vld[i]),
            .pipe_in_rdy  (pipe_in_rdy[i]),
            .pipe_in_fc   (pipe_in_fc[i]),
            .pipe_in_rgb  (pipe_in_rgb[i]),
            .pipe_out_vld (pipe_out_vld[i]),
            .pipe_out_rdy (pipe_out_rdy[i]),
            .pipe_out_fc  (pipe_out_fc[i]),
            .pipe_out_rgb (pipe_out_rgb[i])
        );

        if (i > 0) begin : link            // Slice i fed from slice i-1
            assign pipe_in_vld[i]    = pipe_out_vld[i-1];
            assign pipe_in_fc[i]     = pipe_out_fc[i-1];
            assign pipe_in_rgb[i]    = pipe_out_rgb[i-1];
            assign pipe_out_rdy[i-1] = pipe_in_rdy[i];
        end
    end

    // Chain ends
    assign pipe_in_vld[0]        = stage_in_vld;
    assign pipe_in_fc[0]         = stage_in_fc;
    assign pipe_in_rgb[0]        = stage_in_rgb;
    assign stage_in_rdy          = pipe_in_rdy[0];

    assign pipe_out_rdy[STAGE-1] = stage_out_rdy;
    assign stage_out_vld         = pipe_out_vld[STAGE-1];
    assign stage_out_fc          = pipe_out_fc[STAGE-1];
    assign stage_out_rgb         = pipe_out_rgb[STAGE-1];

endmodule

`default_nettype wire

/* hdl/video_core_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video core top
// Frame controller, position timer and pattern generator feeding
// a chain of pipeline stages towards a valid/ready pixel output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_core_top #(
    parameter int H_ACTIVE = 16,           // Frame width
    parameter int V_ACTIVE = 4,            // Frame height
    parameter int STAGE    = 2             // Output pipeline depth
) (
    input  logic                clk,
    input  logic                reset,

    // Configuration and status
    input  logic                enable,
    input  vga_pkg::pat_mode_t  mode_in,
    input  vga_pkg::rgb_t       solid_in,
    output logic                busy,
    output logic                frame_done,

    // Pixel stream out
    output logic                out_vld,
    input  logic                out_rdy,
    output vga_pkg::vga_fc_t    out_fc,
    output vga_pkg::rgb_t       out_rgb
);

    // Controller and timer
    vga_pkg::vga_pos_t  pos;
    logic               line_last;
    logic               frame_last;
    logic               advance;

    // Controller to generator
    logic               req_vld;
    logic               req_rdy;
    vga_pkg::pix_req_t  req;
    vga_pkg::pat_mode_t mode;
    vga_pkg::rgb_t      solid_rgb;

    // Generator to stages
    logic               stage_in_vld;
    logic               stage_in_rdy;
    vga_pkg::vga_fc_t   stage_in_fc;
    vga_pkg::rgb_t      stage_in_rgb;

    video_frame_ctrl u_video_frame_ctrl (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .mode_in    (mode_in),
        .solid_in   (solid_in),
        .pos        (pos),
        .line_last  (line_last),
        .frame_last (frame_last),
        .advance    (advance),
        .req_vld    (req_vld),
        .req_rdy    (req_rdy),
        .req        (req),
        .mode       (mode),
        .solid_rgb  (solid_rgb),
        .busy       (busy),
        .frame_done (frame_done)
    );

    video_timer #(
        .H_ACTIVE   (H_ACTIVE),
        .V_ACTIVE   (V_ACTIVE)
    ) u_video_timer (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .pos        (pos),
        .line_last  (line_last),
        .frame_last (frame_last)
    );

    video_pattern_gen #(
        .H_ACTIVE   (H_ACTIVE)
    ) u_video_pattern_gen (
        .clk        (clk),
        .reset      (reset),
        .req_vld    (req_vld),
        .req_rdy    (req_rdy),
        .req        (req),
        .mode       (mode),
        .solid_rgb  (solid_rgb),
        .pix_vld    (stage_in_vld),
        .pix_rdy    (stage_in_rdy),
        .pix_fc     (stage_in_fc),
        .pix_rgb    (stage_in_rgb)
    );

    video_core_stages #(
        .RGB_SIZE      (vga_pkg::RGB_SIZE),
        .STAGE         (STAGE)
    ) u_video_core_stages (
        .clk           (clk),
        .reset         (reset),
        .stage_in_vld  (stage_in_vld),
        .stage_in_rdy  (stage_in_rdy),
        .stage_in_fc   (stage_in_fc),
        .stage_in_rgb  (stage_in_rgb),
        .stage_out_rdy (out_rdy),
        .stage_out_vld (out_vld),
        .stage_out_fc  (out_fc),
        .stage_out_rgb (out_rgb)
    );

endmodule

`default_nettype wire

/* hdl/video_frame_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video frame controller
// IDLE/ACTIVE state machine issuing one pixel request per cycle,
// stopping only at frame ends and latching pattern settings per frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_frame_ctrl (
    input  logic                clk,
    input  logic                reset,

    // Configuration
    input  logic                enable,
    input  vga_pkg::pat_mode_t  mode_in,
    input  vga_pkg::rgb_t       solid_in,

    // Timer side
    input  vga_pkg::vga_pos_t   pos,
    input  logic                line_last,
    input  logic                frame_last,
    output logic                advance,

    // Request to pattern generator
    output logic                req_vld,
    input  logic                req_rdy,
    output vga_pkg::pix_req_t   req,
    output vga_pkg::pat_mode_t  mode,
    output vga_pkg::rgb_t       solid_rgb,

    // Status
    output logic                busy,
    output logic                frame_done
);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE
    } state_t;

    state_t             state;
    logic               en_q;              // Registered enable
    logic               sof_xfer;          // Start-of-frame request taken
    vga_pkg::pat_mode_t mode_q;            // Settings of current frame
    vga_pkg::rgb_t      solid_q;

    assign req_vld  = (state == ST_ACTIVE); // Continuous while active
    assign advance  = req_vld & req_rdy;    // Request transfer

    // Marks built from position and timer flags
    assign req.pos    = pos;
    assign req.fc.sof = (pos.x == 8'd0) && (pos.y == 8'd0);
    assign req.fc.eol = line_last;
    assign req.fc.eof = frame_last & line_last;

    assign sof_xfer   = advance & req.fc.sof;
    assign frame_done = advance & req.fc.eof; // One pulse per frame
    assign busy       = req_vld;

    // First pixel already sees the settings that get latched with it
    assign mode      = req.fc.sof ? mode_in : mode_q;
    assign solid_rgb = req.fc.sof ? solid_in : solid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            en_q   <= 1'b0;
            mode_q <= vga_pkg::PAT_SOLID;
        end else begin
            en_q <= enable;
            case (state)
                ST_IDLE: begin
                    if (en_q) state <= ST_ACTIVE;
                end
                ST_ACTIVE: begin
                    if (frame_done && !enable) state <= ST_IDLE; // Stop on frame end only
                end
                default: state <= ST_IDLE;
            endcase
            if (sof_xfer) mode_q <= mode_in;
        end
    end

    always_ff @(posedge clk) begin
        if (sof_xfer) solid_q <= solid_in;   // Colour held for the frame
    end

endmodule

`default_nettype wire

/* hdl/video_pattern_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video pattern generator
// Turns a requested pixel position into an RGB444 colour and holds it
// with its frame marks in one valid/ready output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_pattern_gen #(
    parameter int H_ACTIVE = 16            // Pixels per line, sets bar width
) (
    input  logic                clk,
    input  logic                reset,

    // Request side
    input  logic                req_vld,
    output logic                req_rdy,
    input  vga_pkg::pix_req_t   req,
    input  vga_pkg::pat_mode_t  mode,
    input  vga_pkg::rgb_t       solid_rgb,

    // Pixel side
    output logic                pix_vld,
    input  logic                pix_rdy,
    output vga_pkg::vga_fc_t    pix_fc,
    output vga_pkg::rgb_t       pix_rgb
);

    logic          load;                   // Request taken this cycle
    logic [10:0]   bar_num;                // x*8/H_ACTIVE
    logic [2:0]    bar_idx;
    logic [3:0]    grad_sum;
    vga_pkg::rgb_t colour;                 // Pattern colour of request

    assign req_rdy = !pix_vld || pix_rdy;  // Empty or being drained
    assign load    = req_vld && req_rdy;

    assign bar_num  = {req.pos.x, 3'b000} / 11'(H_ACTIVE);
    assign bar_idx  = bar_num[2:0];        // Always below 8 in active area
    assign grad_sum = req.pos.x[3:0] + req.pos.y[3:0];

    always_comb begin
        colour = '0;
        case (mode)
            vga_pkg::PAT_SOLID: colour = solid_rgb;
            vga_pkg::PAT_BARS: begin
                colour.r = {4{bar_idx[2]}};
                colour.g = {4{bar_idx[1]}};
                colour.b = {4{bar_idx[0]}};
            end
            vga_pkg::PAT_CHECK: begin
                if (req.pos.x[0] ^ req.pos.y[0]) colour = solid_rgb;
            end
            vga_pkg::PAT_GRAD: begin
                colour.r = req.pos.x[3:0];
                colour.g = req.pos.y[3:0];
                colour.b = grad_sum;       // Low bits of x+y
            end
            default: colour = '0;
        endcase
    end

    // Output valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_vld <= 1'b0;
        end else if (load) begin
            pix_vld <= 1'b1;
        end else if (pix_rdy) begin
            pix_vld <= 1'b0;               // Drained with nothing behind
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (load) begin
            pix_fc  <= req.fc;
            pix_rgb <= colour;
        end
    end

endmodule

`default_nettype wire

/* hdl/video_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timer
// Column and row counter stepped once per accepted pixel request,
// flags the last pixel of a line and the last line of a frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_timer #(
    parameter int H_ACTIVE = 16,           // Pixels per line
    parameter int V_ACTIVE = 4             // Lines per frame
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                advance,   // Current pixel accepted
    output vga_pkg::vga_pos_t   pos,       // Current pixel position
    output logic                line_last, // Column is last of line
    output logic                frame_last // Row is last of frame
);

    logic [7:0] col;                       // Column counter
    logic [7:0] row;                       // Row counter

    // Flags decoded straight from the counters
    assign line_last  = (col == 8'(H_ACTIVE - 1));
    assign frame_last = (row == 8'(V_ACTIVE - 1));

    assign pos.x = col;
    assign pos.y = row;

    always_ff @(posedge clk) begin
        if (reset) begin
            col <= 8'd0;
            row <= 8'd0;
        end else if (advance) begin
            if (line_last) begin
                col <= 8'd0;               // Wrap to start of next line
                if (frame_last) begin
                    row <= 8'd0;           // Wrap to top of next frame
                end else begin
                    row <= row + 8'd1;
                end
            end else begin
                col <= col + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the video core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module video_core_tb -f filelist.f -Mdir obj_dir \
    || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/Vvideo_core_tb +verilator+error+limit+1000)
echo "$sim_out"

echo "$sim_out" | grep -q -x -F "** PASS **" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tests/video_core_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video core output checker
// Concurrent assertions on the output handshake and frame marks,
// bound into the core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_core_chk (
    input  logic                clk,
    input  logic                reset,
    input  logic                out_vld,
    input  logic                out_rdy,
    input  vga_pkg::vga_fc_t    out_fc,
    input  vga_pkg::rgb_t       out_rgb
);

    int fail_count = 0;                    // Failed assertion count

    // Stalled pixel must stay put until taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_fc) && $stable(out_rgb)))
    else begin
        $error("Output pixel changed or vanished while stalled");
        fail_count++;
    end

    // Frame end is always also a line end
    a_eof_eol: assert property (@(posedge clk) disable iff (reset)
        (out_vld && out_fc.eof) |-> out_fc.eol)
    else begin
        $error("End of frame mark without end of line mark");
        fail_count++;
    end

    a_reset_quiet: assert property (@(posedge clk) reset |=> !out_vld)
    else begin
        $error("Output valid raised during reset");
        fail_count++;
    end

endmodule

bind video_core_top video_core_chk u_video_core_chk (
    .clk     (clk),
    .reset   (reset),
    .out_vld (out_vld),
    .out_rdy (out_rdy),
    .out_fc  (out_fc),
    .out_rgb (out_rgb)
);

`default_nettype wire

/* tests/video_core_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video core testbench
// Table of pattern runs with mid-frame setting changes and output
// back-pressure, scoreboarded against the pattern rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module video_core_tb;

    localparam int H_ACT     = 8;          // Frame width
    localparam int V_ACT     = 3;          // Frame height
    localparam int STAGES    = 3;          // Output pipeline depth
    localparam int NUM_ROWS  = 5;
    localparam int FRAME_PIX = H_ACT * V_ACT;

    typedef enum logic [1:0] {
        BP_NONE,                           // out_rdy held high
        BP_RAND,                           // Random out_rdy
        BP_STALL                           // Ready 2 of every 5 cycles
    } bp_style_t;

    typedef struct packed {
        vga_pkg::pat_mode_t mode_a;        // Settings of first frame
        vga_pkg::rgb_t      solid_a;
        vga_pkg::pat_mode_t mode_b;        // Applied mid-frame, used from frame 2
        vga_pkg::rgb_t      solid_b;
        logic [3:0]         frames;        // Frames in this run
        bp_style_t          bp;
    } test_row_t;

    logic               clk;
    logic               reset;
    logic               enable;
    vga_pkg::pat_mode_t mode_in;
    vga_pkg::rgb_t      solid_in;
    logic               busy;
    logic               frame_done;
    logic               out_vld;
    logic               out_rdy;
    vga_pkg::vga_fc_t   out_fc;
    vga_pkg::rgb_t      out_rgb;

    test_row_t          rows [NUM_ROWS];
    vga_pkg::rgb_t      exp_rgb [$];       // Expected stream, raster order
    vga_pkg::vga_fc_t   exp_fc [$];
    bp_style_t          bp_style;
    integer             seed = 3;
    logic [31:0]        rnd;
    logic [2:0]         stall_phase;
    int                 rcv_count;         // Accepted output pixels
    int                 done_count;        // frame_done pulses
    int                 cycles;
    int                 cycle_limit;
    int                 total_pix;
    int                 mismatch_errors;
    int                 other_errors;

    video_core_top #(
        .H_ACTIVE   (H_ACT),
        .V_ACTIVE   (V_ACT),
        .STAGE      (STAGES)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .mode_in    (mode_in),
        .solid_in   (solid_in),
        .busy       (busy),
        .frame_done (frame_done),
        .out_vld    (out_vld),
        .out_rdy    (out_rdy),
        .out_fc     (out_fc),
        .out_rgb    (out_rgb)
    );

    always #10 clk = ~clk;                 // 20 ns period

    task automatic check_rgb(input string name, input vga_pkg::rgb_t got,
                             input vga_pkg::rgb_t exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %s: got %h expected %h (pixel %0d)", name, got, exp, rcv_count);
        end
    endtask

    task automatic check_fc(input string name, input vga_pkg::vga_fc_t got,
                            input vga_pkg::vga_fc_t exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %s: got %h expected %h (pixel %0d)", name, got, exp, rcv_count);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatch_errors++;
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    // Colour of one pixel straight from the pattern rules
    function automatic vga_pkg::rgb_t pattern_colour(input vga_pkg::pat_mode_t mode,
                                                     input vga_pkg::rgb_t solid,
                                                     input int x, input int y);
        int            bar;
        vga_pkg::rgb_t c;
        bar = (x * 8) / H_ACT;             // Bar index 0..7
        c   = '0;
        case (mode)
            vga_pkg::PAT_SOLID: c = solid;
            vga_pkg::PAT_BARS: begin
                c.r = bar[2] ? 4'hF : 4'h0;
                c.g = bar[1] ? 4'hF : 4'h0;
                c.b = bar[0] ? 4'hF : 4'h0;
            end
            vga_pkg::PAT_CHECK: begin
                if ((x % 2) != (y % 2)) c = solid; // Odd squares lit
            end
            default: begin                 // Gradient
                c.r = 4'(x % 16);
                c.g = 4'(y % 16);
                c.b = 4'((x + y) % 16);
            end
        endcase
        return c;
    endfunction

    // Queue every pixel and its marks for one table row
    task automatic load_expected(input test_row_t r);
        vga_pkg::pat_mode_t m;
        vga_pkg::rgb_t      s;
        vga_pkg::vga_fc_t   fc;
        for (int f = 0; f < int'(r.frames); f++) begin
            if (f == 0) begin
                m = r.mode_a;
                s = r.solid_a;
            end else begin
                m = r.mode_b;
                s = r.solid_b;
            end
            for (int y = 0; y < V_ACT; y++) begin
                for (int x = 0; x < H_ACT; x++) begin
                    fc.sof = (x == 0) && (y == 0);
                    fc.eol = (x == H_ACT - 1);
                    fc.eof = (x == H_ACT - 1) && (y == V_ACT - 1);
                    exp_fc.push_back(fc);
                    exp_rgb.push_back(pattern_colour(m, s, x, y));
                end
            end
        end
    endtask

    task automatic run_row(input test_row_t r);
        int nframes;
        int rcv_start;
        int done_start;
        int lat;
        nframes    = int'(r.frames);
        rcv_start  = rcv_count;
        done_start = done_count;
        load_expected(r);
        @(posedge clk);
        bp_style = r.bp;                   // Mid-cycle, ahead of next falling edge
        @(negedge clk);
        mode_in  = r.mode_a;
        solid_in = r.solid_a;
        enable   = 1'b1;
        lat      = 0;
        while (!out_vld) begin
            @(negedge clk);
            lat++;
        end
        check_count("fill latency", lat - 1, STAGES + 2); // From the edge that saw enable
        repeat (4) @(negedge clk);
        mode_in  = r.mode_b;               // Must wait for next sof
        solid_in = r.solid_b;
        while (done_count - done_start < nframes - 1) @(negedge clk);
        repeat (8) @(negedge clk);
        enable = 1'b0;                     // Mid-frame of the last frame
        while (rcv_count - rcv_start < nframes * FRAME_PIX) @(negedge clk);
        repeat (10) @(negedge clk);        // Nothing more may follow
        check_count("pixels", rcv_count - rcv_start, nframes * FRAME_PIX);
        check_count("frame_done pulses", done_count - done_start, nframes);
        if (busy) begin
            other_errors++;
            $display("Core still busy after the last frame finished");
        end
    endtask

    // Back-pressure source
    always @(negedge clk) begin
        case (bp_style)
            BP_RAND: begin
                rnd     = $random(seed);
                out_rdy = rnd[0];
            end
            BP_STALL: begin
                out_rdy     = (stall_phase < 3'd2);
                stall_phase = (stall_phase == 3'd4) ? 3'd0 : stall_phase + 3'd1;
            end
            default: out_rdy = 1'b1;
        endcase
    end

    // Scoreboard, samples before the edge updates anything
    always @(posedge clk) begin
        if (!reset) begin
            if (out_vld && out_rdy) begin
                if (exp_rgb.size() == 0) begin
                    other_errors++;
                    $display("Pixel accepted while no pixel was expected");
                end else begin
                    check_rgb("out_rgb", out_rgb, exp_rgb.pop_front());
                    check_fc("out_fc", out_fc, exp_fc.pop_front());
                end
                rcv_count++;
            end
            if (frame_done) done_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, stream never completed", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        enable          = 1'b0;
        mode_in         = vga_pkg::PAT_SOLID;
        solid_in        = '0;
        out_rdy         = 1'b1;
        bp_style        = BP_NONE;
        stall_phase     = 3'd0;
        rcv_count       = 0;
        done_count      = 0;
        cycles          = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        // mode_a, solid_a, mode_b, solid_b, frames, back-pressure
        rows[0] = '{vga_pkg::PAT_SOLID, 12'h5A3, vga_pkg::PAT_BARS,  12'h000, 4'd1, BP_NONE};
        rows[1] = '{vga_pkg::PAT_BARS,  12'h123, vga_pkg::PAT_CHECK, 12'hF0F, 4'd2, BP_NONE};
        rows[2] = '{vga_pkg::PAT_CHECK, 12'h0F0, vga_pkg::PAT_GRAD,  12'h000, 4'd2, BP_RAND};
        rows[3] = '{vga_pkg::PAT_GRAD,  12'h000, vga_pkg::PAT_SOLID, 12'hABC, 4'd3, BP_STALL};
        rows[4] = '{vga_pkg::PAT_SOLID, 12'h777, vga_pkg::PAT_CHECK, 12'h3C5, 4'd1, BP_RAND};
        total_pix = 0;
        for (int i = 0; i < NUM_ROWS; i++) total_pix += int'(rows[i].frames) * FRAME_PIX;
        cycle_limit = total_pix * 4 + 200;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
        $display("Errors: mismatch %0d, other %0d, assertion %0d",
                 mismatch_errors, other_errors, UUT.u_video_core_chk.fail_count);
        if (mismatch_errors + other_errors + UUT.u_video_core_chk.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
